// ==== src/exec_pkg.sv ====
/* widths, opcodes and payload structs shared by the execution back end
   every unit imports this package with a wildcard import */
package exec_pkg;

    parameter int XLEN            = 32;
    parameter int REG_ADDR_WIDTH  = 5;
    parameter int COMMIT_ID_WIDTH = 2;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]           xdata_t;

    typedef enum logic {
        UNIT_ALU    = 1'b0,
        UNIT_MULDIV = 1'b1
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // same order as the M extension funct3
    typedef enum logic [2:0] {
        MD_MUL    = 3'd0,
        MD_MULH   = 3'd1,
        MD_MULHSU = 3'd2,
        MD_MULHU  = 3'd3,
        MD_DIV    = 3'd4,
        MD_DIVU   = 3'd5,
        MD_REM    = 3'd6,
        MD_REMU   = 3'd7
    } muldiv_op_e;

    typedef struct packed {
        unit_e       unit;
        logic [3:0]  op;       // alu_op_e or muldiv_op_e in the low bits
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic        use_imm;
        logic [11:0] imm;      // sign-extended at dispatch
    } issue_req_t;

    typedef struct packed {
        reg_addr_t                  rd;
        xdata_t                     data;
        logic [COMMIT_ID_WIDTH-1:0] id;
    } wb_req_t;

    typedef struct packed {
        reg_addr_t                  rd;
        xdata_t                     data;
        logic [COMMIT_ID_WIDTH-1:0] id;
    } commit_t;

endpackage

// ==== src/gpr.sv ====
/* general register file with two combinational read ports and one write port
   x0 has no storage and always reads as zero */
`timescale 1ns/1ps

module gpr import exec_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  xdata_t    wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output xdata_t    rdata1_o,
    output xdata_t    rdata2_o
);

    xdata_t regs_q [1:31];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;   // writes to x0 dropped
        end
    end

    // no bypass: old value visible during the write cycle
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

// ==== src/dispatch.sv ====
/* operand read, scoreboard hazard check and steering of issued operations
   tags each accepted operation with a rolling commit id */
`timescale 1ns/1ps

module dispatch import exec_pkg::*; #(
    parameter int COMMIT_ID_WIDTH = exec_pkg::COMMIT_ID_WIDTH
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       issue_valid_i,
    input  issue_req_t                 issue_i,
    output logic                       issue_ready_o,
    output reg_addr_t                  rs1_addr_o,
    output reg_addr_t                  rs2_addr_o,
    input  xdata_t                     rs1_rdata_i,
    input  xdata_t                     rs2_rdata_i,
    input  logic                       alu_ready_i,
    input  logic                       muldiv_ready_i,
    output logic                       alu_req_valid_o,
    output logic                       muldiv_req_valid_o,
    output xdata_t                     op1_o,
    output xdata_t                     op2_o,
    output logic [3:0]                 op_o,
    output reg_addr_t                  rd_o,
    output logic [COMMIT_ID_WIDTH-1:0] id_o,
    input  logic                       commit_valid_i,
    input  reg_addr_t                  commit_rd_i
);

    logic [31:0]                pending_q;
    logic [31:0]                pending_d;
    logic [COMMIT_ID_WIDTH-1:0] id_q;
    logic                       hazard;
    logic                       unit_ready;
    logic                       accept;

    assign rs1_addr_o = issue_i.rs1;
    assign rs2_addr_o = issue_i.rs2;

    // rs2 only counts when it is really read
    assign hazard = pending_q[issue_i.rs1]
                  | (pending_q[issue_i.rs2] & ~issue_i.use_imm)
                  | pending_q[issue_i.rd];

    assign unit_ready    = (issue_i.unit == UNIT_ALU) ? alu_ready_i : muldiv_ready_i;
    assign issue_ready_o = ~hazard & unit_ready;
    assign accept        = issue_valid_i & issue_ready_o;

    assign alu_req_valid_o    = accept & (issue_i.unit == UNIT_ALU);
    assign muldiv_req_valid_o = accept & (issue_i.unit == UNIT_MULDIV);

    assign op1_o = rs1_rdata_i;
    assign op2_o = issue_i.use_imm ? {{(XLEN-12){issue_i.imm[11]}}, issue_i.imm}
                                   : rs2_rdata_i;
    assign op_o  = issue_i.op;
    assign rd_o  = issue_i.rd;
    assign id_o  = id_q;

    always_comb begin
        pending_d = pending_q;
        if (commit_valid_i) begin
            pending_d[commit_rd_i] = 1'b0;
        end
        if (accept) begin
            pending_d[issue_i.rd] = 1'b1;
        end
        pending_d[0] = 1'b0;   // x0 never waits
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
            id_q      <= '0;
        end else begin
            pending_q <= pending_d;
            if (accept) begin
                id_q <= id_q + 1'b1;
            end
        end
    end

    // one unit per accepted operation
    assert property (@(posedge clk) disable iff (!arst_n_i)
        !(alu_req_valid_o && muldiv_req_valid_o));

    // write-back only retires registers this scoreboard handed out
    assert property (@(posedge clk) disable iff (!arst_n_i)
        (commit_valid_i && (commit_rd_i != '0)) |-> pending_q[commit_rd_i]);

endmodule

// ==== src/alu.sv ====
/* single-cycle integer ALU feeding a one-entry result slot
   the slot holds its result until write-back grants it */
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       req_valid_i,
    input  alu_op_e                    op_i,
    input  xdata_t                     op1_i,
    input  xdata_t                     op2_i,
    input  reg_addr_t                  rd_i,
    input  logic [COMMIT_ID_WIDTH-1:0] id_i,
    output logic                       ready_o,
    output logic                       wb_valid_o,
    output wb_req_t                    wb_o,
    input  logic                       grant_i
);

    xdata_t     result;
    logic [4:0] shamt;
    logic       valid_q;
    wb_req_t    slot_q;

    assign shamt = op2_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result = op1_i + op2_i;
            ALU_SUB:  result = op1_i - op2_i;
            ALU_AND:  result = op1_i & op2_i;
            ALU_OR:   result = op1_i | op2_i;
            ALU_XOR:  result = op1_i ^ op2_i;
            ALU_SLL:  result = op1_i << shamt;
            ALU_SRL:  result = op1_i >> shamt;
            ALU_SRA:  result = $signed(op1_i) >>> shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op1_i < op2_i};
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (req_valid_i) begin
            valid_q <= 1'b1;
        end else if (grant_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            slot_q <= '{rd: rd_i, data: result, id: id_i};
        end
    end

    assign ready_o    = ~valid_q | grant_i;   // empty or draining now
    assign wb_valid_o = valid_q;
    assign wb_o       = slot_q;

    // a result that lost arbitration waits unchanged
    assert property (@(posedge clk) disable iff (!arst_n_i)
        (valid_q && !grant_i) |=> (valid_q && $stable(slot_q)));

endmodule

// ==== src/muldiv.sv ====
/* iterative multiply/divide unit for the RV32M operations
   32 shift-add or restoring steps on magnitudes then one sign fix-up cycle */
`timescale 1ns/1ps

module muldiv import exec_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       req_valid_i,
    input  muldiv_op_e                 op_i,
    input  xdata_t                     op1_i,
    input  xdata_t                     op2_i,
    input  reg_addr_t                  rd_i,
    input  logic [COMMIT_ID_WIDTH-1:0] id_i,
    input  logic                       grant_i,
    output logic                       ready_o,
    output logic                       wb_valid_o,
    output wb_req_t                    wb_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ITER,
        ST_DONE
    } state_e;

    state_e                     state_q;
    logic [5:0]                 cnt_q;
    logic [2*XLEN-1:0]          acc_q;    // hi holds product or remainder
    xdata_t                     opb_q;    // multiplicand or divisor magnitude
    muldiv_op_e                 op_q;
    logic                       neg_q;    // product or quotient sign
    logic                       rneg_q;   // remainder follows the dividend
    logic                       dz_q;
    reg_addr_t                  rd_q;
    logic [COMMIT_ID_WIDTH-1:0] id_q;
    xdata_t                     res_q;

    logic              is_div;
    logic              sign_a;
    logic              sign_b;
    xdata_t            abs_a;
    xdata_t            abs_b;
    logic [XLEN:0]     add_sum;
    logic [XLEN:0]     div_cand;
    logic [XLEN:0]     div_diff;
    logic [2*XLEN-1:0] acc_step;
    logic [2*XLEN-1:0] prod;
    xdata_t            quo;
    xdata_t            rem;
    xdata_t            result;

    assign is_div = op_i[2];
    assign sign_a = op1_i[XLEN-1] & (op_i inside {MD_MULH, MD_MULHSU, MD_DIV, MD_REM});
    assign sign_b = op2_i[XLEN-1] & (op_i inside {MD_MULH, MD_DIV, MD_REM});
    assign abs_a  = sign_a ? -op1_i : op1_i;
    assign abs_b  = sign_b ? -op2_i : op2_i;

    // one step of either algorithm
    assign add_sum  = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, opb_q} : '0);
    assign div_cand = acc_q[2*XLEN-1:XLEN-1];
    assign div_diff = div_cand - {1'b0, opb_q};

    always_comb begin
        if (!op_q[2]) begin
            acc_step = {add_sum, acc_q[XLEN-1:1]};
        end else if (!div_diff[XLEN]) begin
            acc_step = {div_diff[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
        end else begin
            acc_step = {div_cand[XLEN-1:0], acc_q[XLEN-2:0], 1'b0};   // restore
        end
    end

    // sign fix-up
    // most negative / -1 falls out of the magnitudes on its own
    assign prod = neg_q ? -acc_q : acc_q;
    assign quo  = dz_q ? '1 : (neg_q ? -acc_q[XLEN-1:0] : acc_q[XLEN-1:0]);
    assign rem  = rneg_q ? -acc_q[2*XLEN-1:XLEN] : acc_q[2*XLEN-1:XLEN];

    always_comb begin
        case (op_q)
            MD_MUL:                       result = prod[XLEN-1:0];
            MD_MULH, MD_MULHSU, MD_MULHU: result = prod[2*XLEN-1:XLEN];
            MD_DIV, MD_DIVU:              result = quo;
            default:                      result = rem;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= ST_ITER;
                        cnt_q   <= '0;
                    end
                end
                ST_ITER: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == 6'd32) begin
                        state_q <= ST_DONE;   // fix-up cycle done
                    end
                end
                ST_DONE: begin
                    if (grant_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && (state_q == ST_IDLE)) begin
            acc_q  <= {{XLEN{1'b0}}, abs_a};
            opb_q  <= abs_b;
            op_q   <= op_i;
            neg_q  <= sign_a ^ sign_b;
            rneg_q <= sign_a;
            dz_q   <= is_div & (op2_i == '0);
            rd_q   <= rd_i;
            id_q   <= id_i;
        end else if (state_q == ST_ITER) begin
            if (cnt_q == 6'd32) begin
                res_q <= result;
            end else begin
                acc_q <= acc_step;
            end
        end
    end

    assign ready_o    = (state_q == ST_IDLE);
    assign wb_valid_o = (state_q == ST_DONE);
    assign wb_o       = '{rd: rd_q, data: res_q, id: id_q};

    // dispatch must not issue into a busy unit
    assert property (@(posedge clk) disable iff (!arst_n_i)
        req_valid_i |-> (state_q == ST_IDLE));

endmodule

// ==== src/wbu.sv ====
/* write-back arbiter for the two unit results
   drives the register write port and the commit report in the same cycle */
`timescale 1ns/1ps

module wbu import exec_pkg::*; (
    input  logic      alu_valid_i,
    input  wb_req_t   alu_wb_i,
    input  logic      muldiv_valid_i,
    input  wb_req_t   muldiv_wb_i,
    output logic      alu_grant_o,
    output logic      muldiv_grant_o,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,
    output xdata_t    reg_wdata_o,
    output logic      commit_valid_o,
    output commit_t   commit_o
);

    wb_req_t sel;

    // muldiv first since it has been busy for 33 cycles
    assign muldiv_grant_o = muldiv_valid_i;
    assign alu_grant_o    = alu_valid_i & ~muldiv_valid_i;

    assign sel = muldiv_valid_i ? muldiv_wb_i : alu_wb_i;

    assign reg_we_o    = alu_valid_i | muldiv_valid_i;
    assign reg_waddr_o = sel.rd;
    assign reg_wdata_o = sel.data;

    assign commit_valid_o = reg_we_o;   // x0 writes still reported
    assign commit_o       = '{rd: sel.rd, data: sel.data, id: sel.id};

endmodule

// ==== src/exec_top.sv ====
/* execution back end: dispatch, ALU, mul/div unit, write-back and registers
   takes decoded operations on the issue port and reports each register write */
`timescale 1ns/1ps

module exec_top import exec_pkg::*; #(
    parameter int COMMIT_ID_WIDTH = exec_pkg::COMMIT_ID_WIDTH
) (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       issue_valid_i,
    output logic       issue_ready_o,
    input  issue_req_t issue_i,
    output logic       commit_valid_o,
    output commit_t    commit_o
);

    // register file ports
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xdata_t    rs1_rdata;
    xdata_t    rs2_rdata;
    logic      reg_we;
    reg_addr_t reg_waddr;
    xdata_t    reg_wdata;

    // dispatch to units
    logic                       alu_req_valid;
    logic                       muldiv_req_valid;
    xdata_t                     disp_op1;
    xdata_t                     disp_op2;
    logic [3:0]                 disp_op;
    reg_addr_t                  disp_rd;
    logic [COMMIT_ID_WIDTH-1:0] disp_id;

    // unit results
    logic    alu_ready;
    logic    muldiv_ready;
    logic    alu_wb_valid;
    logic    muldiv_wb_valid;
    logic    alu_grant;
    logic    muldiv_grant;
    wb_req_t alu_wb;
    wb_req_t muldiv_wb;

    gpr u_gpr (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .we_i    (reg_we),
        .waddr_i (reg_waddr),
        .wdata_i (reg_wdata),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_rdata),
        .rdata2_o(rs2_rdata)
    );

    dispatch #(
        .COMMIT_ID_WIDTH(COMMIT_ID_WIDTH)
    ) u_dispatch (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .issue_valid_i     (issue_valid_i),
        .issue_i           (issue_i),
        .issue_ready_o     (issue_ready_o),
        .rs1_addr_o        (rs1_addr),
        .rs2_addr_o        (rs2_addr),
        .rs1_rdata_i       (rs1_rdata),
        .rs2_rdata_i       (rs2_rdata),
        .alu_ready_i       (alu_ready),
        .muldiv_ready_i    (muldiv_ready),
        .alu_req_valid_o   (alu_req_valid),
        .muldiv_req_valid_o(muldiv_req_valid),
        .op1_o             (disp_op1),
        .op2_o             (disp_op2),
        .op_o              (disp_op),
        .rd_o              (disp_rd),
        .id_o              (disp_id),
        .commit_valid_i    (commit_valid_o),
        .commit_rd_i       (commit_o.rd)    // scoreboard clears on commit
    );

    alu u_alu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_valid_i(alu_req_valid),
        .op_i       (alu_op_e'(disp_op)),
        .op1_i      (disp_op1),
        .op2_i      (disp_op2),
        .rd_i       (disp_rd),
        .id_i       (disp_id),
        .ready_o    (alu_ready),
        .wb_valid_o (alu_wb_valid),
        .wb_o       (alu_wb),
        .grant_i    (alu_grant)
    );

    muldiv u_muldiv (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_valid_i(muldiv_req_valid),
        .op_i       (muldiv_op_e'(disp_op[2:0])),
        .op1_i      (disp_op1),
        .op2_i      (disp_op2),
        .rd_i       (disp_rd),
        .id_i       (disp_id),
        .grant_i    (muldiv_grant),
        .ready_o    (muldiv_ready),
        .wb_valid_o (muldiv_wb_valid),
        .wb_o       (muldiv_wb)
    );

    wbu u_wbu (
        .alu_valid_i   (alu_wb_valid),
        .alu_wb_i      (alu_wb),
        .muldiv_valid_i(muldiv_wb_valid),
        .muldiv_wb_i   (muldiv_wb),
        .alu_grant_o   (alu_grant),
        .muldiv_grant_o(muldiv_grant),
        .reg_we_o      (reg_we),
        .reg_waddr_o   (reg_waddr),
        .reg_wdata_o   (reg_wdata),
        .commit_valid_o(commit_valid_o),
        .commit_o      (commit_o)
    );

endmodule

// ==== bench/tb_exec_top.sv ====
/* testbench for exec_top: a seeded random issue stream is checked each cycle against
   a model of the scoreboard, both units and the write-back priority */
`timescale 1ns/1ps

module tb_exec_top import exec_pkg::*; ();

    localparam int NUM_OPS         = 400;
    localparam int SETUP_OPS       = 3;      // loads of x8 and x9 ahead of the random ops
    localparam int TOTAL_OPS       = NUM_OPS + SETUP_OPS;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40;
    localparam int MULDIV_WAIT     = 33;     // cycles in the iterate state

    logic       clk;
    logic       arst_n_i;
    logic       issue_valid_i;
    logic       issue_ready_o;
    issue_req_t issue_i;
    logic       commit_valid_o;
    commit_t    commit_o;

    xdata_t                     model_regs [32];
    logic [31:0]                pend;               // uncommitted destinations
    logic [COMMIT_ID_WIDTH-1:0] next_id;
    commit_t                    alu_exp;            // ids wrap, so one expected entry per unit
    commit_t                    md_exp;
    logic                       alu_full;
    logic                       md_busy;
    int                         md_left;            // cycles until the mul/div result shows
    logic                       fire;
    int                         presented;
    int                         accepted;

    exec_top #(
        .COMMIT_ID_WIDTH(COMMIT_ID_WIDTH)
    ) dut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_i       (issue_i),
        .commit_valid_o(commit_valid_o),
        .commit_o      (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic xdata_t alu_result(input alu_op_e op, input xdata_t a, input xdata_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return $signed(a) >>> sh;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return '0;
        endcase
    endfunction

    // RV32M rules, including divide by zero and signed overflow
    function automatic xdata_t muldiv_result(input muldiv_op_e op, input xdata_t a,
                                             input xdata_t b);
        logic signed [63:0] p_ss;
        logic signed [63:0] p_su;
        logic [63:0]        p_uu;
        logic signed [31:0] qa;
        logic signed [31:0] qb;
        logic               overflow;
        p_ss     = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        p_su     = $signed({{32{a[31]}}, a}) * $signed({32'd0, b});
        p_uu     = {32'd0, a} * {32'd0, b};
        qa       = a;
        qb       = b;
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        if (!op[2]) begin
            case (op)
                MD_MUL:    return p_ss[31:0];
                MD_MULH:   return p_ss[63:32];
                MD_MULHSU: return p_su[63:32];
                default:   return p_uu[63:32];
            endcase
        end
        if (b == '0) begin
            return ((op == MD_DIV) || (op == MD_DIVU)) ? '1 : a;
        end
        if (overflow && (op == MD_DIV)) begin
            return a;
        end
        if (overflow && (op == MD_REM)) begin
            return '0;
        end
        case (op)
            MD_DIV:  return qa / qb;
            MD_DIVU: return a / b;
            MD_REM:  return qa % qb;
            default: return a % b;
        endcase
    endfunction

    function automatic issue_req_t make_op(input int idx);
        issue_req_t op;
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $urandom;
        r2 = $urandom;
        op = '0;
        if (idx < SETUP_OPS) begin
            // x8 = -1, x9 = 1 << 31
            op.unit    = UNIT_ALU;
            op.use_imm = 1'b1;
            op.op      = (idx == 2) ? ALU_SLL : ALU_ADD;
            op.rd      = (idx == 0) ? 5'd8 : 5'd9;
            op.rs1     = (idx == 2) ? 5'd9 : 5'd0;
            op.imm     = (idx == 0) ? 12'hfff : ((idx == 1) ? 12'd1 : 12'd31);
            return op;
        end
        op.rd  = {2'b00, r1[2:0]};                  // x8 and x9 stay untouched
        op.rs1 = reg_addr_t'(r1[10:3] % 8'd10);
        op.rs2 = reg_addr_t'(r2[23:16] % 8'd10);
        op.imm = r2[11:0];
        if (r1[11:10] == 2'b00) begin
            op.unit    = UNIT_MULDIV;
            op.op      = {1'b0, r1[14:12]};
            op.use_imm = r1[20] & r1[21];
            if (r1[23:22] == 2'b00) begin
                op.op      = {2'b01, r1[24], 1'b0};   // div or rem
                op.rs1     = 5'd9;
                op.rs2     = r1[25] ? 5'd8 : 5'd0;  // by -1 or by zero
                op.use_imm = 1'b0;
            end
        end else begin
            op.unit    = UNIT_ALU;
            op.op      = 4'(r1[19:12] % 8'd10);
            op.use_imm = r1[20];
        end
        return op;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_commit(input logic got_valid, input commit_t got,
                                input logic want_valid, input commit_t want);
        if (got_valid !== want_valid) begin
            report_mismatch($sformatf("commit_valid_o %b, expected %b", got_valid, want_valid));
        end else if (want_valid && (got !== want)) begin
            report_mismatch($sformatf(
                "commit rd %0d data %h id %0d, expected rd %0d data %h id %0d",
                got.rd, got.data, got.id, want.rd, want.data, want.id));
        end
    endtask

    task automatic check_ready(input logic got, input logic want);
        if (got !== want) begin
            report_mismatch($sformatf("issue_ready_o %b, expected %b", got, want));
        end
    endtask

    // one cycle of the model, checked mid-cycle where all outputs are settled
    task automatic step_cycle();
        logic    md_now;
        logic    alu_now;
        logic    want_valid;
        logic    want_ready;
        logic    hazard;
        commit_t want;
        xdata_t  a;
        xdata_t  b;
        xdata_t  res;
        md_now     = md_busy && (md_left == 0);
        alu_now    = alu_full && !md_now;        // alu result waits behind mul/div
        want_valid = md_now || alu_full;
        want       = md_now ? md_exp : alu_exp;
        check_commit(commit_valid_o, commit_o, want_valid, want);

        hazard = pend[issue_i.rs1] || (pend[issue_i.rs2] && !issue_i.use_imm)
               || pend[issue_i.rd];
        if (issue_i.unit == UNIT_ALU) begin
            want_ready = !hazard && (!alu_full || alu_now);
        end else begin
            want_ready = !hazard && !md_busy;
        end
        check_ready(issue_ready_o, want_ready);
        fire = issue_valid_i && want_ready;

        if (want_valid) begin
            pend[want.rd] = 1'b0;
        end
        if (md_now) begin
            md_busy = 1'b0;
        end else if (md_busy) begin
            md_left--;
        end
        if (alu_now) begin
            alu_full = 1'b0;
        end

        if (fire) begin
            a = model_regs[issue_i.rs1];
            b = issue_i.use_imm ? {{(XLEN-12){issue_i.imm[11]}}, issue_i.imm}
                                : model_regs[issue_i.rs2];
            if (issue_i.unit == UNIT_ALU) begin
                res      = alu_result(alu_op_e'(issue_i.op), a, b);
                alu_full = 1'b1;
                alu_exp  = '{rd: issue_i.rd, data: res, id: next_id};
            end else begin
                res     = muldiv_result(muldiv_op_e'(issue_i.op[2:0]), a, b);
                md_busy = 1'b1;
                md_left = MULDIV_WAIT;
                md_exp  = '{rd: issue_i.rd, data: res, id: next_id};
            end
            if (issue_i.rd != '0) begin
                model_regs[issue_i.rd] = res;
                pend[issue_i.rd]       = 1'b1;
            end
            next_id = next_id + 1'b1;
            accepted++;
        end
    endtask

    task automatic drive_request();
        logic [31:0] r;
        r = $urandom;
        if (fire || !issue_valid_i) begin   // a stalled request stays put
            if ((presented < TOTAL_OPS) && (r[2:0] != 3'd0)) begin
                issue_i       <= make_op(presented);
                issue_valid_i <= 1'b1;
                presented++;
            end else begin
                issue_valid_i <= 1'b0;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h5714));
        arst_n_i      <= 1'b0;
        issue_valid_i <= 1'b0;
        issue_i       <= '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        pend      = '0;
        next_id   = '0;
        alu_exp   = '0;
        md_exp    = '0;
        alu_full  = 1'b0;
        md_busy   = 1'b0;
        md_left   = 0;
        fire      = 1'b0;
        presented = 0;
        accepted  = 0;
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
        while (!((accepted == TOTAL_OPS) && !alu_full && !md_busy)) begin
            @(negedge clk);
            step_cycle();
            @(posedge clk);
            drive_request();
        end
        // a late duplicate commit would show in these idle cycles
        repeat (4) begin
            @(negedge clk);
            step_cycle();
        end
        $display("Simulation passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: commits stopped arriving within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== project.f ====
src/exec_pkg.sv
src/gpr.sv
src/dispatch.sv
src/alu.sv
src/muldiv.sv
src/wbu.sv
src/exec_top.sv
bench/tb_exec_top.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run, the exit status tells pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 -f project.f --top-module tb_exec_top -Mdir obj_dir &&
./obj_dir/Vtb_exec_top || { echo "simulation run failed" >&2; exit 1; }
